// ==== hw/cdcPkg.sv ====
/* cdcPkg: shared widths, depth and frame types of the sample bridge
   from the write clock domain into the read clock domain */
package cdcPkg;

    // ======================================================================
    // Widths and depth
    // ======================================================================
    localparam int SampleWidth = 12;    // One input sample
    localparam int SeqWidth    = 4;     // Sequence number per frame
    localparam int GapWidth    = 4;     // Refused-write count per frame
    localparam int FifoDepth   = 4;     // Power of two, at least 4
    localparam int LostWidth   = 16;    // Running lost-sample total

    // Refused count stops here
    localparam logic [GapWidth-1:0] GapMax = '1;

    // ======================================================================
    // Frame types
    // ======================================================================

    // Word stored in the crossing FIFO
    typedef struct packed {
        logic [SeqWidth-1:0]    seq;    // Sequence stamp
        logic [GapWidth-1:0]    gap;    // Refused writes before this one
        logic [SampleWidth-1:0] data;   // Sample payload
    } frame_t;

    // Word presented at the read port
    typedef struct packed {
        logic [GapWidth-1:0]    gap;
        logic [SampleWidth-1:0] data;
    } outSample_t;

    // FIFO payload width
    localparam int FrameWidth = $bits(frame_t);

endpackage

// ==== hw/asyncFifo.sv ====
`timescale 1ns/10ps
/* asyncFifo: dual-clock FIFO, gray pointers compared asynchronously with a
   direction flag; empty and full assert at once and release over two flops */
module asyncFifo #(
    parameter int Width = 20,   // Word width
    parameter int Depth = 4     // Power of two, at least 4
) (
    // Read side
    input  logic             rclk,
    input  logic             aempty,    // Async reset, active high
    input  logic             r,         // Read trigger
    output logic [Width-1:0] rd,        // Read data
    output logic             rok,       // Not empty
    // Write side
    input  logic             wclk,
    input  logic             w,         // Write trigger
    input  logic [Width-1:0] wd,        // Write data
    output logic             wok,       // Not full
    output logic             wReset     // Reset released on wclk
);
    localparam int AddrMsb = $clog2(Depth) - 1;

    logic [Width-1:0] mem [Depth];
    logic [AddrMsb:0] rbAddr, rgAddr;   // Read pointer, binary and gray
    logic [AddrMsb:0] wbAddr, wgAddr;   // Write pointer, binary and gray
    logic [AddrMsb:0] rbAddrNext;
    logic [AddrMsb:0] wbAddrNext;
    logic [1:0]       wResetSync;
    logic             rEmpty, rEmpty2;
    logic             wFull, wFull2;
    logic             dir;              // Set when heading for full
    logic             emptyCond;
    logic             fullCond;
    logic             rEmptyForce;
    logic             wFullForce;
    logic             dirSet;
    logic             dirClr;

    // ======================================================================
    // Write-domain reset
    // ======================================================================
    // Asserts with aempty, releases after two wclk edges
    always_ff @(posedge wclk or posedge aempty) begin
        if (aempty) begin
            wResetSync <= 2'b11;
        end else begin
            wResetSync <= {wResetSync[0], 1'b0};
        end
    end

    assign wReset = wResetSync[1];

    // ======================================================================
    // Read side
    // ======================================================================
    assign rbAddrNext = rbAddr + 1'b1;

    always_ff @(posedge rclk or posedge aempty) begin
        if (aempty) begin
            rbAddr <= '0;
            rgAddr <= '0;
        end else if (r && !rEmpty) begin
            rbAddr <= rbAddrNext;
            rgAddr <= rbAddrNext ^ (rbAddrNext >> 1);  // Binary to gray
        end
    end

    // Empty sets at once, clears two rclk edges later
    assign rEmptyForce = emptyCond | aempty;

    always_ff @(posedge rclk or posedge rEmptyForce) begin
        if (rEmptyForce) begin
            {rEmpty, rEmpty2} <= 2'b11;
        end else begin
            {rEmpty, rEmpty2} <= {rEmpty2, 1'b0};
        end
    end

    assign rd  = mem[rbAddr];       // Combinational from read pointer
    assign rok = !rEmpty;

    // ======================================================================
    // Write side
    // ======================================================================
    assign wbAddrNext = wbAddr + 1'b1;

    always_ff @(posedge wclk) begin
        if (w && !wFull) begin
            mem[wbAddr] <= wd;      // Lands on the accepting edge
        end
    end

    always_ff @(posedge wclk or posedge wReset) begin
        if (wReset) begin
            wbAddr <= '0;
            wgAddr <= '0;
        end else if (w && !wFull) begin
            wbAddr <= wbAddrNext;
            wgAddr <= wbAddrNext ^ (wbAddrNext >> 1);
        end
    end

    // Held full through reset and its release
    assign wFullForce = fullCond | wReset;

    always_ff @(posedge wclk or posedge wFullForce) begin
        if (wFullForce) begin
            {wFull, wFull2} <= 2'b11;
        end else begin
            {wFull, wFull2} <= {wFull2, 1'b0};
        end
    end

    assign wok = !wFull;

    // ======================================================================
    // Asynchronous comparison
    // ======================================================================
    assign emptyCond = (rgAddr == wgAddr) && !dir;
    assign fullCond  = (rgAddr == wgAddr) && dir;

    // Writer one quadrant behind reader: going full
    assign dirSet = (rgAddr[AddrMsb] == wgAddr[AddrMsb-1])
                 && (rgAddr[AddrMsb-1] != wgAddr[AddrMsb]);
    // Writer one quadrant ahead: going empty, also on reset
    assign dirClr = ((rgAddr[AddrMsb] != wgAddr[AddrMsb-1])
                 && (rgAddr[AddrMsb-1] == wgAddr[AddrMsb])) || aempty;

    always_ff @(posedge dirSet or posedge dirClr) begin
        if (dirClr) begin
            dir <= 1'b0;
        end else begin
            dir <= 1'b1;
        end
    end

endmodule

// ==== hw/sampleFramer.sv ====
`timescale 1ns/10ps
/* sampleFramer: stamps accepted samples with a sequence number and the
   count of writes refused since the last acceptance */
module sampleFramer (
    input  logic                           wclk,
    input  logic                           wReset,  // From FIFO synchronizer
    input  logic                           w,       // Write trigger
    input  logic [cdcPkg::SampleWidth-1:0] wd,      // Sample in
    input  logic                           fifoWok, // FIFO has room
    output logic                           push,    // Write into FIFO
    output cdcPkg::frame_t                 frame    // Framed word
);
    logic [cdcPkg::SeqWidth-1:0] seqNum;    // Stamp for next accepted
    logic [cdcPkg::GapWidth-1:0] refused;   // Refused since last accept

    // ======================================================================
    // Combinational push and frame
    // ======================================================================
    assign push = w && fifoWok;             // Accepted sample

    always_comb begin
        frame.seq  = seqNum;
        frame.gap  = refused;
        frame.data = wd;                    // Straight from the port
    end

    // ======================================================================
    // Sequence and refused-write count
    // ======================================================================
    always_ff @(posedge wclk or posedge wReset) begin
        if (wReset) begin
            seqNum  <= '0;
            refused <= '0;
        end else if (push) begin
            seqNum  <= seqNum + 1'b1;       // Wraps
            refused <= '0;                  // Count rode on this frame
        end else if (w && (refused != cdcPkg::GapMax)) begin
            refused <= refused + 1'b1;      // Refused write, saturating
        end
    end

endmodule

// ==== hw/sampleDeframer.sv ====
`timescale 1ns/10ps
/* sampleDeframer: read-side output register with sequence check and a
   saturating total of samples lost at the write side */
module sampleDeframer (
    input  logic                         rclk,
    input  logic                         aempty,    // Async reset
    input  logic                         fifoRok,   // FIFO has a word
    input  cdcPkg::frame_t               frame,     // FIFO head word
    input  logic                         r,         // Read trigger
    output logic                         pop,       // Take FIFO head
    output logic                         rok,       // rd valid
    output cdcPkg::outSample_t           rd,
    output logic [cdcPkg::LostWidth-1:0] lostCount,
    output logic                         seqErr     // Sticky
);
    localparam int PadWidth = cdcPkg::LostWidth + 1 - cdcPkg::GapWidth;

    logic                         outValid;
    cdcPkg::outSample_t           outReg;
    logic [cdcPkg::SeqWidth-1:0]  expSeq;     // Next expected stamp
    logic [cdcPkg::LostWidth:0]   lostSum;    // One bit of headroom
    logic                         load;

    // ======================================================================
    // Output register control
    // ======================================================================
    // Load when empty or being consumed
    assign load = fifoRok && (!outValid || r);
    assign pop  = load;
    assign rok  = outValid;
    assign rd   = outReg;

    always_ff @(posedge rclk or posedge aempty) begin
        if (aempty) begin
            outValid <= 1'b0;
        end else if (load) begin
            outValid <= 1'b1;
        end else if (r) begin
            outValid <= 1'b0;               // Consumed, nothing behind it
        end
    end

    // Payload
    always_ff @(posedge rclk) begin
        if (load) begin
            outReg.gap  <= frame.gap;
            outReg.data <= frame.data;
        end
    end

    // ======================================================================
    // Sequence check and lost total
    // ======================================================================
    assign lostSum = {1'b0, lostCount} + {{PadWidth{1'b0}}, frame.gap};

    always_ff @(posedge rclk or posedge aempty) begin
        if (aempty) begin
            expSeq    <= '0;
            seqErr    <= 1'b0;
            lostCount <= '0;
        end else if (load) begin
            if (frame.seq != expSeq) begin
                seqErr <= 1'b1;             // Held until reset
            end
            expSeq <= frame.seq + 1'b1;     // Resync on the received stamp
            if (lostSum[cdcPkg::LostWidth]) begin
                lostCount <= '1;            // Saturate
            end else begin
                lostCount <= lostSum[cdcPkg::LostWidth-1:0];
            end
        end
    end

endmodule

// ==== hw/sampleBridge.sv ====
`timescale 1ns/10ps
/* sampleBridge: carries framed 12-bit samples from wclk into rclk through
   a dual-clock FIFO */
module sampleBridge (
    // Write side
    input  logic                           wclk,
    input  logic                           w,           // Write trigger
    input  logic [cdcPkg::SampleWidth-1:0] wd,
    output logic                           wok,         // Room for a sample
    // Read side
    input  logic                           rclk,
    input  logic                           aempty,      // Async reset
    input  logic                           r,           // Read trigger
    output cdcPkg::outSample_t             rd,
    output logic                           rok,         // rd valid
    output logic [cdcPkg::LostWidth-1:0]   lostCount,   // Saturating total
    output logic                           seqErr       // Sequence break seen
);
    cdcPkg::frame_t wFrame;     // Framer to FIFO
    cdcPkg::frame_t rFrame;     // FIFO to deframer
    logic           push;
    logic           pop;
    logic           fifoRok;
    logic           wReset;

    // ======================================================================
    // Write domain
    // ======================================================================
    sampleFramer i_sampleFramer (
        .wclk    (wclk),
        .wReset  (wReset),
        .w       (w),
        .wd      (wd),
        .fifoWok (wok),         // FIFO space is the bridge's wok
        .push    (push),
        .frame   (wFrame)
    );

    // ======================================================================
    // Crossing
    // ======================================================================
    asyncFifo #(
        .Width (cdcPkg::FrameWidth),
        .Depth (cdcPkg::FifoDepth)
    ) i_asyncFifo (
        .rclk   (rclk),
        .aempty (aempty),
        .r      (pop),
        .rd     (rFrame),
        .rok    (fifoRok),
        .wclk   (wclk),
        .w      (push),
        .wd     (wFrame),
        .wok    (wok),
        .wReset (wReset)
    );

    // ======================================================================
    // Read domain
    // ======================================================================
    sampleDeframer i_sampleDeframer (
        .rclk      (rclk),
        .aempty    (aempty),
        .fifoRok   (fifoRok),
        .frame     (rFrame),
        .r         (r),
        .pop       (pop),
        .rok       (rok),
        .rd        (rd),
        .lostCount (lostCount),
        .seqErr    (seqErr)
    );

endmodule

// ==== tb/sampleBridge_checker.sv ====
`timescale 1ns/10ps
/* sampleBridge_checker: handshake and reset properties of the sample bridge,
   bound into the top level */
module sampleBridge_checker (
    input logic               rclk,
    input logic               aempty,
    input logic               r,
    input logic               rok,
    input logic               wok,
    input logic               seqErr,
    input cdcPkg::outSample_t rd
);
    int assertFails = 0;    // Summed into the testbench result

    // Held output word must not move
    rdStable: assert property (@(posedge rclk) disable iff (aempty)
        (rok && !r) |=> $stable(rd))
        else begin
            $error("rd changed while rok high and r low");
            assertFails++;
        end

    // Stream is sequenced at the source
    noSeqErr: assert property (@(posedge rclk) disable iff (aempty) !seqErr)
        else begin
            $error("seqErr raised");
            assertFails++;
        end

    // Both handshakes closed in reset
    resetQuiet: assert property (@(posedge rclk) aempty |-> (!rok && !wok))
        else begin
            $error("rok or wok high during reset");
            assertFails++;
        end

endmodule

bind sampleBridge sampleBridge_checker i_bridgeChecker (
    .rclk   (rclk),
    .aempty (aempty),
    .r      (r),
    .rok    (rok),
    .wok    (wok),
    .seqErr (seqErr),
    .rd     (rd)
);

// ==== tb/bridgeScoreboard.sv ====
`timescale 1ns/10ps
/* bridgeScoreboard: predicts read-port words from accepted writes and
   compares them, with the lost total, at each consume */
module bridgeScoreboard (
    input  logic                           wclk,
    input  logic                           rclk,
    input  logic                           aempty,
    input  logic                           w,
    input  logic [cdcPkg::SampleWidth-1:0] wd,
    input  logic                           wok,
    input  logic                           r,
    input  cdcPkg::outSample_t             rd,
    input  logic                           rok,
    input  logic [cdcPkg::LostWidth-1:0]   lostCount,
    input  logic                           seqErr,
    output int                             accepted,    // Samples taken at wclk
    output int                             consumed,    // Words taken at rclk
    output int                             passCount,
    output int                             failCount
);
    cdcPkg::outSample_t           expQ[$];      // Words in flight
    cdcPkg::outSample_t           want;
    logic [cdcPkg::GapWidth-1:0]  pendGap;      // Refused since last accept
    logic [cdcPkg::LostWidth-1:0] expLost;      // Predicted lost total

    // Read word for a sample accepted after refusedCnt refusals
    function automatic cdcPkg::outSample_t expectedWord(
        input logic [cdcPkg::GapWidth-1:0]    refusedCnt,
        input logic [cdcPkg::SampleWidth-1:0] sample
    );
        cdcPkg::outSample_t word;
        word.gap  = refusedCnt;
        word.data = sample;
        return word;
    endfunction

    // Lost total stops at its maximum
    function automatic logic [cdcPkg::LostWidth-1:0] addLost(
        input logic [cdcPkg::LostWidth-1:0] total,
        input logic [cdcPkg::GapWidth-1:0]  gap
    );
        int sum;
        sum = int'(total) + int'(gap);
        if (sum > (1 << cdcPkg::LostWidth) - 1) begin
            return '1;
        end
        return sum[cdcPkg::LostWidth-1:0];
    endfunction

    // ======================================================================
    // Write side: accepts and refusals
    // ======================================================================
    always @(posedge wclk) begin
        if (aempty) begin
            pendGap  = '0;
            accepted = 0;
            expQ.delete();
        end else if (w && wok) begin
            expQ.push_back(expectedWord(pendGap, wd));
            pendGap  = '0;                  // Count rides on this one
            accepted = accepted + 1;
        end else if (w && pendGap != '1) begin
            pendGap = pendGap + 1'b1;       // Refused, saturating
        end
    end

    // ======================================================================
    // Read side: compare on consume
    // ======================================================================
    always @(posedge rclk) begin
        if (aempty) begin
            expLost   = '0;
            consumed  = 0;
            passCount = 0;
            failCount = 0;
        end else if (r && rok) begin
            consumed = consumed + 1;
            if (expQ.size() == 0) begin
                $display("ERR @%0t: word %h read with nothing expected", $time, rd.data);
                failCount = failCount + 1;
            end else begin
                want    = expQ.pop_front();
                expLost = addLost(expLost, want.gap);   // Includes the word shown
                if (rd !== want || lostCount !== expLost || seqErr !== 1'b0) begin
                    $display("ERR @%0t: got gap %0d data %h lost %0d seqErr %b, want %0d %h %0d",
                             $time, rd.gap, rd.data, lostCount, seqErr,
                             want.gap, want.data, expLost);
                    failCount = failCount + 1;
                end else begin
                    passCount = passCount + 1;
                end
            end
        end
    end

endmodule

// ==== tb/sampleBridge_tb.sv ====
`timescale 1ns/10ps
/* sampleBridge_tb: clocks, reset, directed and random traffic through the
   sample bridge, one result line per test */
module sampleBridge_tb;
    localparam real WclkPeriod = 11.0;      // Write clock, ns

    logic                           rclk = 1'b0;
    logic                           wclk = 1'b0;
    logic                           aempty;
    logic                           w;
    logic                           r;
    logic [cdcPkg::SampleWidth-1:0] wd;
    logic                           wok;
    logic                           rok;
    logic                           seqErr;
    logic [cdcPkg::LostWidth-1:0]   lostCount;
    cdcPkg::outSample_t             rd;
    cdcPkg::outSample_t             held;       // Word parked under back-pressure
    int                             accepted;
    int                             consumed;
    int                             passCount;
    int                             failCount;
    int                             seed = 32'h983a_d9fb;
    int                             tbErrors = 0;
    int                             testsRun = 0;
    int                             testsFailed = 0;
    int                             errMark = 0;
    int                             wordMark = 0;
    int                             fillCount;
    bit                             writerDone;

    always #4 rclk = ~rclk;                     // 8 ns
    always #(WclkPeriod / 2.0) wclk = ~wclk;

    sampleBridge i_sampleBridge (.*);
    bridgeScoreboard i_bridgeScoreboard (.*);

    function automatic int errorTotal();
        return failCount + tbErrors + i_sampleBridge.i_bridgeChecker.assertFails;
    endfunction

    task automatic expectTrue(input string what, input bit cond);
        if (!cond) begin
            $display("ERR @%0t: %s does not hold", $time, what);
            tbErrors++;
        end
    endtask

    task automatic endTest(input string name);
        int errs;
        errs = errorTotal() - errMark;
        testsRun++;
        if (errs != 0) begin
            testsFailed++;
        end
        $display("Test %-12s %4d words checked, %0d errors", name, passCount - wordMark, errs);
        errMark  = errorTotal();
        wordMark = passCount;
    endtask

    // r high until every accepted sample is out
    task automatic waitDrained();
        int cycles;
        cycles = 0;
        @(posedge rclk);
        #1;
        r = 1'b1;
        while (consumed != accepted && cycles < 500) begin
            @(posedge rclk);
            cycles++;
        end
        if (consumed != accepted) begin
            $display("Timeout: %0d accepted samples never reached rd", accepted - consumed);
            tbErrors++;
        end
    endtask

    // Offers samples only while wok is high, so none are refused
    task automatic writeStream(input int count);
        int target;
        int cycles;
        target = accepted + count;
        cycles = 0;
        while (accepted < target && cycles < 50 * count) begin
            @(posedge wclk);
            #1;
            cycles++;
            w  = wok && (accepted < target);
            wd = wd + 1'b1;
        end
        w = 1'b0;
        if (accepted < target) begin
            $display("Timeout: only %0d of %0d samples accepted", count - target + accepted, count);
            tbErrors++;
        end
    endtask

    task automatic fillUntilFull(output int count);
        int start;
        int cycles;
        start  = accepted;
        cycles = 0;
        do begin
            @(posedge wclk);
            #1;
            cycles++;
            w  = wok;                           // Stops as wok falls
            wd = wd + 1'b1;
        end while (wok && cycles < 60);
        count = accepted - start;
        if (wok) begin
            $display("Timeout: wok stayed high with r held low");
            tbErrors++;
        end
    endtask

    task automatic randomWrites(input int cycles);
        int rnd;
        repeat (cycles) begin
            @(posedge wclk);
            #1;
            rnd = $random(seed);
            w   = (rnd[1:0] != 2'b00);          // Three in four
            wd  = rnd[15:4];
        end
        w = 1'b0;
    endtask

    task automatic randomReads();
        int rnd;
        int cycles;
        cycles = 0;
        while (!writerDone && cycles < 2000) begin
            @(posedge rclk);
            #1;
            rnd = $random(seed);
            r   = rnd[0];
            cycles++;
        end
        if (!writerDone) begin
            $display("Timeout: random writer never finished");
            tbErrors++;
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        int cycles;
        aempty     = 1'b0;
        w          = 1'b0;
        r          = 1'b0;
        wd         = '0;
        writerDone = 1'b0;
        #1;
        aempty = 1'b1;

        // Reset
        repeat (4) @(posedge rclk);
        expectTrue("rok low in reset", !rok);
        expectTrue("wok low in reset", !wok);
        expectTrue("lostCount zero in reset", lostCount == '0);
        expectTrue("seqErr low in reset", !seqErr);
        #1;
        aempty = 1'b0;
        #1;
        expectTrue("rok low after reset", !rok);
        expectTrue("wok low after reset", !wok);     // wReset still syncing
        expectTrue("lostCount zero after reset", lostCount == '0);
        expectTrue("seqErr low after reset", !seqErr);
        cycles = 0;
        while (!wok && cycles < 20) begin
            @(posedge wclk);
            cycles++;
        end
        if (!wok) begin
            $display("Timeout: wok never rose after reset");
            tbErrors++;
        end
        endTest("reset");

        // In-order stream, no read stalls
        @(posedge rclk);
        #1;
        r = 1'b1;
        writeStream(24);
        waitDrained();
        endTest("in-order");

        // Back-pressure
        @(posedge rclk);
        #1;
        r = 1'b0;
        fillUntilFull(fillCount);
        expectTrue("at most FifoDepth+1 accepted before full",
                   fillCount <= cdcPkg::FifoDepth + 1);
        cycles = 0;
        while (!rok && cycles < 20) begin
            @(posedge rclk);
            cycles++;
        end
        #1;
        held = rd;
        repeat (10) @(posedge rclk);
        #1;
        expectTrue("rd held while r low", rok && rd == held);
        waitDrained();
        endTest("backpressure");

        // Refused writes, a short and a long stall
        fork
            begin
                repeat (90) begin
                    @(posedge wclk);
                    #1;
                    w  = 1'b1;
                    wd = wd + 12'h011;
                end
                w = 1'b0;
            end
            begin
                @(posedge rclk);
                #1;
                r = 1'b0;
                repeat (12) @(posedge rclk);
                #1;
                r = 1'b1;
                repeat (20) @(posedge rclk);
                #1;
                r = 1'b0;
                repeat (40) @(posedge rclk);   // Long enough to saturate
                #1;
                r = 1'b1;
            end
        join
        waitDrained();
        expectTrue("refused writes counted", lostCount != '0);
        endTest("refused");

        // Random traffic on both sides
        fork
            begin
                randomWrites(500);
                writerDone = 1'b1;
            end
            randomReads();
        join
        waitDrained();
        endTest("random");

        $display("Tests run %0d, failed %0d; words checked %0d; errors %0d",
                 testsRun, testsFailed, passCount, errorTotal());
        if (errorTotal() == 0 && testsFailed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hw/cdcPkg.sv
hw/asyncFifo.sv
hw/sampleFramer.sv
hw/sampleDeframer.sv
hw/sampleBridge.sv
tb/sampleBridge_checker.sv
tb/bridgeScoreboard.sv
tb/sampleBridge_tb.sv

// ==== Makefile ====
# Verilator flow for the sample bridge testbench
BUILD = obj_dir

.PHONY: build run clean

build:
	verilator --binary --timing --assert -j 0 --top-module sampleBridge_tb -Mdir $(BUILD) -f tb.f

# Result comes from the log, the simulator status is not trusted
run: build
	-./$(BUILD)/VsampleBridge_tb +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "Run failed, see sim.log"; exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) sim.log
